/* core_tile.f */
design/core_tile_pkg.sv
design/pipe_reg.sv
design/tile_mem.sv
design/desc_engine.sv
design/core_tile_pr.sv
dv/core_tile_assert.sv
dv/core_tile_checker.sv
dv/core_tile_tb.sv

/* design/core_tile_pkg.sv */
package core_tile_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int DATA_WIDTH  = 128;
  localparam int STRB_WIDTH  = DATA_WIDTH / 8;
  localparam int MEM_LINES   = 64;
  localparam int ADDR_WIDTH  = $clog2(MEM_LINES);
  localparam int LANE_COUNT  = 4;
  localparam int LANE_WIDTH  = DATA_WIDTH / LANE_COUNT;
  localparam int COUNT_WIDTH = 16;

  //////////////////////////////////////////////////////////////////////
  // Descriptor opcodes and channel payloads
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_ADD   = 2'd1,
    OP_XOR   = 2'd2,
    OP_CLEAR = 2'd3
  } desc_op_e;

  // One DMA write beat
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
  } dma_wr_cmd_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } dma_rd_cmd_t;

  // Value is the operand going in and the lane result coming out
  typedef struct packed {
    logic [7:0]                  tag;
    desc_op_e                    op;
    logic [ADDR_WIDTH-1:0]       addr;
    logic [$clog2(LANE_COUNT)-1:0] lane;
    logic [13:0]                 pad;
    logic [LANE_WIDTH-1:0]       value;
  } desc_t;

  // Engine side of the scratch memory
  typedef struct packed {
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } mem_req_t;

endpackage

/* design/core_tile_pr.sv */
module core_tile_pr (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // DMA commands
  input  core_tile_pkg::dma_wr_cmd_t            dma_wr,
  input  logic                                  dma_wr_valid,
  output logic                                  dma_wr_ready,
  input  core_tile_pkg::dma_rd_cmd_t            dma_rd,
  input  logic                                  dma_rd_valid,
  output logic                                  dma_rd_ready,

  // DMA read responses
  output logic [core_tile_pkg::DATA_WIDTH-1:0]  dma_resp_data,
  output logic                                  dma_resp_valid,
  input  logic                                  dma_resp_ready,

  // Descriptors
  input  core_tile_pkg::desc_t                  in_desc,
  input  logic                                  in_desc_valid,
  output logic                                  in_desc_ready,
  output core_tile_pkg::desc_t                  out_desc,
  output logic                                  out_desc_valid,
  input  logic                                  out_desc_ready,

  output logic [core_tile_pkg::COUNT_WIDTH-1:0] status_count
);

  import core_tile_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Channel registers
  //////////////////////////////////////////////////////////////////////

  dma_wr_cmd_t dma_wr_r;
  logic        dma_wr_valid_r;
  logic        dma_wr_ready_r;

  pipe_reg #(.WIDTH($bits(dma_wr_cmd_t))) dma_wr_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_data  (dma_wr),
    .s_valid (dma_wr_valid),
    .s_ready (dma_wr_ready),
    .m_data  (dma_wr_r),
    .m_valid (dma_wr_valid_r),
    .m_ready (dma_wr_ready_r)
  );

  dma_rd_cmd_t dma_rd_r;
  logic        dma_rd_valid_r;
  logic        dma_rd_ready_r;

  pipe_reg #(.WIDTH($bits(dma_rd_cmd_t))) dma_rd_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_data  (dma_rd),
    .s_valid (dma_rd_valid),
    .s_ready (dma_rd_ready),
    .m_data  (dma_rd_r),
    .m_valid (dma_rd_valid_r),
    .m_ready (dma_rd_ready_r)
  );

  logic [DATA_WIDTH-1:0] resp_data_n;
  logic                  resp_valid_n;
  logic                  resp_ready_n;

  pipe_reg #(.WIDTH(DATA_WIDTH)) dma_resp_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_data  (resp_data_n),
    .s_valid (resp_valid_n),
    .s_ready (resp_ready_n),
    .m_data  (dma_resp_data),
    .m_valid (dma_resp_valid),
    .m_ready (dma_resp_ready)
  );

  desc_t in_desc_r;
  logic  in_desc_valid_r;
  logic  in_desc_ready_r;

  pipe_reg #(.WIDTH($bits(desc_t))) in_desc_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_data  (in_desc),
    .s_valid (in_desc_valid),
    .s_ready (in_desc_ready),
    .m_data  (in_desc_r),
    .m_valid (in_desc_valid_r),
    .m_ready (in_desc_ready_r)
  );

  desc_t out_desc_n;
  logic  out_desc_valid_n;
  logic  out_desc_ready_n;

  pipe_reg #(.WIDTH($bits(desc_t))) out_desc_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_data  (out_desc_n),
    .s_valid (out_desc_valid_n),
    .s_ready (out_desc_ready_n),
    .m_data  (out_desc),
    .m_valid (out_desc_valid),
    .m_ready (out_desc_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Tile logic
  //////////////////////////////////////////////////////////////////////

  mem_req_t               eng_req;
  logic                   eng_req_valid;
  logic                   eng_req_ready;
  logic [DATA_WIDTH-1:0]  eng_rd_data;
  logic [COUNT_WIDTH-1:0] done_count;

  tile_mem tile_mem_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_cmd        (dma_wr_r),
    .wr_valid      (dma_wr_valid_r),
    .wr_ready      (dma_wr_ready_r),
    .rd_cmd        (dma_rd_r),
    .rd_valid      (dma_rd_valid_r),
    .rd_ready      (dma_rd_ready_r),
    .resp_data     (resp_data_n),
    .resp_valid    (resp_valid_n),
    .resp_ready    (resp_ready_n),
    .eng_req       (eng_req),
    .eng_req_valid (eng_req_valid),
    .eng_req_ready (eng_req_ready),
    .eng_rd_data   (eng_rd_data)
  );

  desc_engine desc_engine_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_desc       (in_desc_r),
    .in_valid      (in_desc_valid_r),
    .in_ready      (in_desc_ready_r),
    .out_desc      (out_desc_n),
    .out_valid     (out_desc_valid_n),
    .out_ready     (out_desc_ready_n),
    .eng_req       (eng_req),
    .eng_req_valid (eng_req_valid),
    .eng_req_ready (eng_req_ready),
    .eng_rd_data   (eng_rd_data),
    .done_count    (done_count)
  );

  // Status trails the engine counter by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      status_count <= '0;
    end else begin
      status_count <= done_count;
    end
  end

endmodule

/* design/desc_engine.sv */
module desc_engine (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // Incoming descriptors
  input  core_tile_pkg::desc_t                  in_desc,
  input  logic                                  in_valid,
  output logic                                  in_ready,

  // Completed descriptors
  output core_tile_pkg::desc_t                  out_desc,
  output logic                                  out_valid,
  input  logic                                  out_ready,

  // Scratch memory port
  output core_tile_pkg::mem_req_t               eng_req,
  output logic                                  eng_req_valid,
  input  logic                                  eng_req_ready,
  input  logic [core_tile_pkg::DATA_WIDTH-1:0]  eng_rd_data,

  output logic [core_tile_pkg::COUNT_WIDTH-1:0] done_count
);

  import core_tile_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    MODIFY,
    WRITE,
    SEND
  } state_e;

  state_e                state;
  desc_t                 desc_q;
  logic [LANE_WIDTH-1:0] result_q;

  logic [LANE_WIDTH-1:0] lane_old;
  logic [LANE_WIDTH-1:0] lane_new;
  logic [LANE_WIDTH-1:0] lane_ret;
  logic [DATA_WIDTH-1:0] line_new;

  logic in_fire;
  logic out_fire;
  logic req_fire;

  assign in_ready  = (state == IDLE);
  assign out_valid = (state == SEND);
  assign in_fire   = in_valid & in_ready;
  assign out_fire  = out_valid & out_ready;
  assign req_fire  = eng_req_valid & eng_req_ready;

  //////////////////////////////////////////////////////////////////////
  // Lane update
  //////////////////////////////////////////////////////////////////////

  assign lane_old = eng_rd_data[desc_q.lane*LANE_WIDTH +: LANE_WIDTH];

  // READ and CLEAR return the old lane, ADD and XOR the new one
  always_comb begin
    lane_new = lane_old;
    lane_ret = lane_old;
    case (desc_q.op)
      OP_ADD: begin
        lane_new = lane_old + desc_q.value;
        lane_ret = lane_new;
      end
      OP_XOR: begin
        lane_new = lane_old ^ desc_q.value;
        lane_ret = lane_new;
      end
      OP_CLEAR: begin
        lane_new = '0;
      end
      default: begin
        lane_new = lane_old;
      end
    endcase
    line_new = eng_rd_data;
    line_new[desc_q.lane*LANE_WIDTH +: LANE_WIDTH] = lane_new;
  end

  // Write goes out straight from MODIFY, WRITE only retries a stall
  always_comb begin
    eng_req.we    = (state != READ);
    eng_req.addr  = desc_q.addr;
    eng_req.data  = line_new;
    eng_req_valid = (state == READ) || (state == WRITE) ||
                    (state == MODIFY && desc_q.op != OP_READ);
  end

  always_comb begin
    out_desc       = desc_q;
    out_desc.value = result_q;
  end

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= IDLE;
      done_count <= '0;
    end else begin
      if (out_fire) begin
        done_count <= done_count + 1'b1;
      end
      case (state)
        IDLE: begin
          if (in_fire) state <= READ;
        end
        READ: begin
          if (req_fire) state <= MODIFY;
        end
        MODIFY: begin
          if (desc_q.op == OP_READ || req_fire) begin
            state <= SEND;
          end else begin
            state <= WRITE;
          end
        end
        WRITE: begin
          if (req_fire) state <= SEND;
        end
        SEND: begin
          if (out_fire) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      desc_q <= in_desc;
    end
    if (state == MODIFY) begin
      result_q <= lane_ret;
    end
  end

endmodule

/* design/pipe_reg.sv */
module pipe_reg #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,

  input  logic [WIDTH-1:0] s_data,
  input  logic             s_valid,
  output logic             s_ready,

  output logic [WIDTH-1:0] m_data,
  output logic             m_valid,
  input  logic             m_ready
);

  logic [WIDTH-1:0] skid_data;
  logic             skid_valid;
  logic             s_fire;
  logic             m_free;

  // Ready depends only on the skid flop, so no path runs through
  assign s_ready = ~skid_valid;
  assign s_fire  = s_valid & s_ready;

  // Output register can take a new item this cycle
  assign m_free  = m_ready | ~m_valid;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (m_free) begin
      // Skid entry drains first, input is blocked meanwhile
      m_valid    <= skid_valid | s_fire;
      skid_valid <= 1'b0;
    end else if (s_fire) begin
      // Output stalled, park the beat that was already in flight
      skid_valid <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (m_free) begin
      m_data <= skid_valid ? skid_data : s_data;
    end
    if (!m_free && s_fire) begin
      skid_data <= s_data;
    end
  end

endmodule

/* design/tile_mem.sv */
module tile_mem (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // DMA write port
  input  core_tile_pkg::dma_wr_cmd_t           wr_cmd,
  input  logic                                 wr_valid,
  output logic                                 wr_ready,

  // DMA read port and its response
  input  core_tile_pkg::dma_rd_cmd_t           rd_cmd,
  input  logic                                 rd_valid,
  output logic                                 rd_ready,
  output logic [core_tile_pkg::DATA_WIDTH-1:0] resp_data,
  output logic                                 resp_valid,
  input  logic                                 resp_ready,

  // Descriptor engine port
  input  core_tile_pkg::mem_req_t              eng_req,
  input  logic                                 eng_req_valid,
  output logic                                 eng_req_ready,
  output logic [core_tile_pkg::DATA_WIDTH-1:0] eng_rd_data
);

  import core_tile_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_LINES];

  logic wr_fire;
  logic rd_fire;
  logic resp_fire;
  logic eng_fire;

  //////////////////////////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////////////////////////

  // Engine always wins, its read-modify-write stays atomic
  assign eng_req_ready = 1'b1;
  assign eng_fire      = eng_req_valid & eng_req_ready;

  assign wr_ready  = ~eng_req_valid;
  // One response slot keeps DMA reads in command order
  assign rd_ready  = ~eng_req_valid & (~resp_valid | resp_ready);

  assign wr_fire   = wr_valid & wr_ready;
  assign rd_fire   = rd_valid & rd_ready;
  assign resp_fire = resp_valid & resp_ready;

  //////////////////////////////////////////////////////////////////////
  // Line array
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (eng_fire && eng_req.we) begin
      mem[eng_req.addr] <= eng_req.data;
    end else if (wr_fire) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wr_cmd.strb[i]) begin
          mem[wr_cmd.addr][i*8 +: 8] <= wr_cmd.data[i*8 +: 8];
        end
      end
    end
  end

  // Engine read data, held until the next engine read
  always_ff @(posedge clk) begin
    if (eng_fire && !eng_req.we) begin
      eng_rd_data <= mem[eng_req.addr];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // DMA read response register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (rd_fire) begin
      resp_valid <= 1'b1;
    end else if (resp_fire) begin
      resp_valid <= 1'b0;
    end
  end

  // Same-edge DMA write is not yet visible here
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      resp_data <= mem[rd_cmd.addr];
    end
  end

endmodule

/* dv/core_tile_assert.sv */
module core_tile_assert (
  input logic                                  clk,
  input logic                                  rst_n,
  input logic [core_tile_pkg::DATA_WIDTH-1:0]  dma_resp_data,
  input logic                                  dma_resp_valid,
  input logic                                  dma_resp_ready,
  input core_tile_pkg::desc_t                  out_desc,
  input logic                                  out_desc_valid,
  input logic                                  out_desc_ready,
  input logic [core_tile_pkg::COUNT_WIDTH-1:0] status_count
);

  timeunit 1ns;
  timeprecision 100ps;

  int resp_fails   = 0;
  int desc_fails   = 0;
  int reset_fails  = 0;
  int status_fails = 0;
  int fail_count;

  assign fail_count = resp_fails + desc_fails + reset_fails + status_fails;

  //////////////////////////////////////////////////////////////////////
  // Output channels hold until taken
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (!rst_n)
    dma_resp_valid && !dma_resp_ready |=> dma_resp_valid && $stable(dma_resp_data))
  else begin
    resp_fails++;
    $error("dma_resp dropped or changed before dma_resp_ready");
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_desc_valid && !out_desc_ready |=> out_desc_valid && $stable(out_desc))
  else begin
    desc_fails++;
    $error("out_desc dropped or changed before out_desc_ready");
  end

  // Covers every reset cycle and the first cycle after it
  assert property (@(posedge clk)
    !rst_n |=> !dma_resp_valid && !out_desc_valid && status_count == '0)
  else begin
    reset_fails++;
    $error("Output valid or status_count not cleared by reset");
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    rst_n |=> status_count >= $past(status_count))
  else begin
    status_fails++;
    $error("status_count decreased");
  end

endmodule

bind core_tile_pr core_tile_assert assert_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .dma_resp_data  (dma_resp_data),
  .dma_resp_valid (dma_resp_valid),
  .dma_resp_ready (dma_resp_ready),
  .out_desc       (out_desc),
  .out_desc_valid (out_desc_valid),
  .out_desc_ready (out_desc_ready),
  .status_count   (status_count)
);

/* dv/core_tile_checker.sv */
module core_tile_checker (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  core_tile_pkg::dma_wr_cmd_t            dma_wr,
  input  logic                                  dma_wr_valid,
  input  logic                                  dma_wr_ready,
  input  core_tile_pkg::dma_rd_cmd_t            dma_rd,
  input  logic                                  dma_rd_valid,
  input  logic                                  dma_rd_ready,
  input  logic [core_tile_pkg::DATA_WIDTH-1:0]  dma_resp_data,
  input  logic                                  dma_resp_valid,
  input  logic                                  dma_resp_ready,
  input  core_tile_pkg::desc_t                  in_desc,
  input  logic                                  in_desc_valid,
  input  logic                                  in_desc_ready,
  input  core_tile_pkg::desc_t                  out_desc,
  input  logic                                  out_desc_valid,
  input  logic                                  out_desc_ready,
  input  logic [core_tile_pkg::COUNT_WIDTH-1:0] status_count,
  input  int                                    assert_errs,
  input  logic                                  finish_req,
  output int                                    rd_pending,
  output int                                    desc_pending,
  output int                                    err_total,
  output logic                                  report_done
);

  timeunit 1ns;
  timeprecision 100ps;

  import core_tile_pkg::*;

  logic [DATA_WIDTH-1:0] model [MEM_LINES];
  logic [DATA_WIDTH-1:0] exp_rd [$];
  desc_t                 exp_desc [$];

  int rd_errs     = 0;
  int desc_errs   = 0;
  int status_errs = 0;
  int proto_errs  = 0;
  int out_count   = 0;

  initial begin
    rd_pending   = 0;
    desc_pending = 0;
    err_total    = 0;
    report_done  = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and comparison
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : track
    desc_t                 d;
    logic [DATA_WIDTH-1:0] got_line;
    logic [LANE_WIDTH-1:0] old_lane;
    logic [LANE_WIDTH-1:0] new_lane;
    if (rst_n) begin
      // Read sees the line before a write of the same cycle
      if (dma_rd_valid && dma_rd_ready) begin
        exp_rd.push_back(model[dma_rd.addr]);
      end
      if (dma_wr_valid && dma_wr_ready) begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (dma_wr.strb[b]) model[dma_wr.addr][b*8 +: 8] = dma_wr.data[b*8 +: 8];
        end
      end
      if (in_desc_valid && in_desc_ready) begin
        d        = in_desc;
        old_lane = model[d.addr][d.lane*LANE_WIDTH +: LANE_WIDTH];
        case (d.op)
          OP_ADD:   new_lane = old_lane + d.value;
          OP_XOR:   new_lane = old_lane ^ d.value;
          OP_CLEAR: new_lane = '0;
          default:  new_lane = old_lane;
        endcase
        model[d.addr][d.lane*LANE_WIDTH +: LANE_WIDTH] = new_lane;
        // READ and CLEAR hand back the old lane
        d.value = (d.op == OP_ADD || d.op == OP_XOR) ? new_lane : old_lane;
        exp_desc.push_back(d);
      end

      if (dma_resp_valid && dma_resp_ready) begin
        if (exp_rd.size() == 0) begin
          $display("DMA read response at %0t with no read outstanding", $time);
          proto_errs++;
        end else begin
          got_line = exp_rd.pop_front();
          if (dma_resp_data !== got_line) begin
            $display("ERR %0t dma_resp_data got %h exp %h", $time, dma_resp_data, got_line);
            rd_errs++;
          end
        end
      end
      if (out_desc_valid && out_desc_ready) begin
        out_count++;
        if (exp_desc.size() == 0) begin
          $display("Output descriptor at %0t with no descriptor outstanding", $time);
          proto_errs++;
        end else begin
          d = exp_desc.pop_front();
          if (out_desc !== d) begin
            $display("ERR %0t out_desc got %h exp %h", $time, out_desc, d);
            desc_errs++;
          end
        end
      end

      // Closing summary once the stimulus is done
      if (finish_req && !report_done) begin
        if (status_count !== out_count[COUNT_WIDTH-1:0]) begin
          $display("ERR %0t status_count got %0d exp %0d", $time, status_count, out_count);
          status_errs++;
        end
        if (exp_rd.size() != 0 || exp_desc.size() != 0) begin
          $display("Run ended with %0d read responses and %0d descriptors missing",
                   exp_rd.size(), exp_desc.size());
          proto_errs++;
        end
        $display("Error counts: read=%0d desc=%0d status=%0d protocol=%0d assert=%0d",
                 rd_errs, desc_errs, status_errs, proto_errs, assert_errs);
        err_total   <= rd_errs + desc_errs + status_errs + proto_errs + assert_errs;
        report_done <= 1'b1;
      end
    end
    rd_pending   <= exp_rd.size();
    desc_pending <= exp_desc.size();
  end

endmodule

/* dv/core_tile_tb.sv */
module core_tile_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import core_tile_pkg::*;

  localparam logic [31:0] SEED = 32'h28092a89;
  localparam int N_RAND_WR   = 96;
  localparam int N_DESC      = 80;
  localparam int TOTAL_TXNS  = 3 * MEM_LINES + N_RAND_WR + N_DESC;
  localparam int CYCLE_LIMIT = 40 * TOTAL_TXNS;

  logic clk = 1'b0;
  logic rst_n;

  dma_wr_cmd_t            dma_wr;
  logic                   dma_wr_valid;
  logic                   dma_wr_ready;
  dma_rd_cmd_t            dma_rd;
  logic                   dma_rd_valid;
  logic                   dma_rd_ready;
  logic [DATA_WIDTH-1:0]  dma_resp_data;
  logic                   dma_resp_valid;
  logic                   dma_resp_ready;
  desc_t                  in_desc;
  logic                   in_desc_valid;
  logic                   in_desc_ready;
  desc_t                  out_desc;
  logic                   out_desc_valid;
  logic                   out_desc_ready;
  logic [COUNT_WIDTH-1:0] status_count;

  integer stim_seed;
  integer bp_seed;
  int     cycles = 0;
  logic   finish_req;
  logic   report_done;
  int     err_total;
  int     rd_pending;
  int     desc_pending;

  always #2 clk = ~clk;

  core_tile_pr uut (.*);

  core_tile_checker chk (
    .assert_errs (uut.assert_inst.fail_count),
    .*
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers, all entered on a falling edge
  //////////////////////////////////////////////////////////////////////

  function automatic logic [DATA_WIDTH-1:0] rand_line();
    logic [DATA_WIDTH-1:0] line;
    for (int i = 0; i < LANE_COUNT; i++) begin
      line[i*LANE_WIDTH +: LANE_WIDTH] = $random(stim_seed);
    end
    return line;
  endfunction

  // Ready is registered, so its value now holds through the next rising edge
  task automatic send_wr(input dma_wr_cmd_t cmd);
    dma_wr       = cmd;
    dma_wr_valid = 1'b1;
    while (!dma_wr_ready) @(negedge clk);
    @(negedge clk);
    dma_wr_valid = 1'b0;
  endtask

  task automatic send_rd(input dma_rd_cmd_t cmd);
    dma_rd       = cmd;
    dma_rd_valid = 1'b1;
    while (!dma_rd_ready) @(negedge clk);
    @(negedge clk);
    dma_rd_valid = 1'b0;
  endtask

  task automatic send_desc(input desc_t d);
    in_desc       = d;
    in_desc_valid = 1'b1;
    while (!in_desc_ready) @(negedge clk);
    @(negedge clk);
    in_desc_valid = 1'b0;
  endtask

  task automatic read_all_lines();
    dma_rd_cmd_t rd;
    for (int i = 0; i < MEM_LINES; i++) begin
      rd.addr = i[ADDR_WIDTH-1:0];
      send_rd(rd);
      repeat ($random(stim_seed) & 1) @(negedge clk);
    end
    while (rd_pending != 0) @(negedge clk);
  endtask

  // Random back-pressure on both output channels
  always @(negedge clk) begin
    dma_resp_ready = ($random(bp_seed) & 3) != 0;
    out_desc_ready = ($random(bp_seed) & 3) != 0;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test phases
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    dma_wr_cmd_t wr;
    desc_t       d;
    logic [31:0] rnd;
    stim_seed      = SEED;
    bp_seed        = ~SEED;
    rst_n          = 1'b0;
    dma_wr         = '0;
    dma_wr_valid   = 1'b0;
    dma_rd         = '0;
    dma_rd_valid   = 1'b0;
    in_desc        = '0;
    in_desc_valid  = 1'b0;
    dma_resp_ready = 1'b0;
    out_desc_ready = 1'b0;
    finish_req     = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Full lines first so no byte stays unknown
    for (int i = 0; i < MEM_LINES; i++) begin
      wr.addr = i[ADDR_WIDTH-1:0];
      wr.data = rand_line();
      wr.strb = '1;
      send_wr(wr);
    end
    for (int i = 0; i < N_RAND_WR; i++) begin
      rnd     = $random(stim_seed);
      wr.addr = rnd[ADDR_WIDTH-1:0];
      wr.strb = rnd[31:16];
      wr.data = rand_line();
      send_wr(wr);
      repeat (rnd[8]) @(negedge clk);
    end
    while (uut.dma_wr_valid_r) @(negedge clk);

    read_all_lines();

    for (int i = 0; i < N_DESC; i++) begin
      rnd     = $random(stim_seed);
      d.tag   = i[7:0];
      d.op    = desc_op_e'(rnd[1:0]);
      // Half go to a few lines so lanes get hit more than once
      d.addr  = rnd[10] ? rnd[7:2] : {3'b000, rnd[4:2]};
      d.lane  = rnd[9:8];
      d.pad   = '0;
      d.value = $random(stim_seed);
      send_desc(d);
    end
    while (desc_pending != 0) @(negedge clk);

    read_all_lines();

    finish_req = 1'b1;
    while (!report_done) @(negedge clk);
    if (err_total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core_tile testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module core_tile_tb -Mdir "$build_dir" -o core_tile_sim \
  -f core_tile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/core_tile_sim" +verilator+error+limit+1000 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTS FAILED" "$log_file"; then
  echo "Failure reported in $log_file"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
